// ==== project.f ====
hdl/lsu_pkg.sv
hdl/load_unit.sv
hdl/store_unit.sv
hdl/load_store_unit.sv
hdl/store_buffer.sv
hdl/data_ram.sv
hdl/lsu_top.sv
dv/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_lsu -Mdir obj_dir -f project.f; then
    echo "verilator build failed"
    exit 1
fi

# $fatal in the testbench gives a non-zero exit status
if ! ./obj_dir/Vtb_lsu; then
    echo "simulation failed"
    exit 1
fi

exit 0

// ==== dv/tb_lsu.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_lsu;

    localparam int NUM_RANDOM     = 200;
    localparam int NUM_DIRECTED   = 30;
    localparam int TIMEOUT_CYCLES = 20 * (NUM_RANDOM + NUM_DIRECTED) + 100;
    localparam lsu_pkg::data_word_t WINDOW_BASE = 32'h0000_0100;   // 16-word random window

    logic                   clk_i = 1'b0;
    logic                   reset_i;
    lsu_pkg::instr_packet_t instr_packet_i;
    logic                   ldu_valid_i;
    lsu_pkg::data_word_t    ldu_address_i;
    lsu_pkg::ldu_uop_t      ldu_uop_i;
    logic                   stu_valid_i;
    lsu_pkg::data_word_t    stu_address_i;
    lsu_pkg::data_word_t    stu_data_i;
    lsu_pkg::stu_uop_t      stu_uop_i;
    logic                   ldu_idle_o;
    logic                   stu_idle_o;
    lsu_pkg::instr_packet_t instr_packet_o;
    lsu_pkg::data_word_t    data_o;
    logic                   data_valid_o;

    // byte-addressed copy of the RAM, written at store commit
    logic [7:0]          ref_mem [1024];

    // expectations indexed by tag
    bit                  exp_is_load   [64];
    bit                  exp_trap      [64];
    lsu_pkg::data_word_t exp_addr      [64];
    lsu_pkg::data_word_t exp_wdata     [64];
    lsu_pkg::ldu_uop_t   exp_load_uop  [64];
    lsu_pkg::stu_uop_t   exp_store_uop [64];
    int                  sent_count    [64];
    int                  seen_count    [64];
    int                  commit_cycle  [64];
    int                  issued_count;
    int                  commit_count;
    int                  cycle_count;
    bit                  first_issue;

    lsu_pkg::tag_t          out_tag;
    logic                   commit_known;
    lsu_pkg::instr_packet_t want_packet;
    lsu_pkg::data_word_t    want_data;

    lsu_top i_dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_packet_i (instr_packet_i),
        .ldu_valid_i    (ldu_valid_i),
        .ldu_address_i  (ldu_address_i),
        .ldu_uop_i      (ldu_uop_i),
        .stu_valid_i    (stu_valid_i),
        .stu_address_i  (stu_address_i),
        .stu_data_i     (stu_data_i),
        .stu_uop_i      (stu_uop_i),
        .ldu_idle_o     (ldu_idle_o),
        .stu_idle_o     (stu_idle_o),
        .instr_packet_o (instr_packet_o),
        .data_o         (data_o),
        .data_valid_o   (data_valid_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("[FAIL] t=%0t %s", $time, what));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // an access must sit on a multiple of its own size
    function automatic logic store_misaligned(input lsu_pkg::data_word_t addr,
                                              input lsu_pkg::stu_uop_t uop);
        int size;
        size = (uop == lsu_pkg::STU_SW) ? 4 : (uop == lsu_pkg::STU_SH) ? 2 : 1;
        return (addr % size) != 0;
    endfunction

    // little-endian lane select with sign or zero extension
    function automatic lsu_pkg::data_word_t expected_load(input lsu_pkg::data_word_t addr,
                                                          input lsu_pkg::ldu_uop_t uop);
        logic [9:0] a;
        logic [7:0] b0, b1, b2, b3;
        a = addr[9:0];
        if (uop == lsu_pkg::LDU_LW) a[1:0] = 2'b00;   // unused offset bits dropped
        else if (uop == lsu_pkg::LDU_LH || uop == lsu_pkg::LDU_LHU) a[0] = 1'b0;
        b0 = ref_mem[a];
        b1 = ref_mem[a + 10'd1];
        b2 = ref_mem[a + 10'd2];
        b3 = ref_mem[a + 10'd3];
        case (uop)
            lsu_pkg::LDU_LB:  return {{24{b0[7]}}, b0};
            lsu_pkg::LDU_LBU: return {24'h0, b0};
            lsu_pkg::LDU_LH:  return {{16{b1[7]}}, b1, b0};
            lsu_pkg::LDU_LHU: return {16'h0, b1, b0};
            default:          return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic lsu_pkg::ldu_uop_t load_code(input int sel);
        case (sel % 5)
            0:       return lsu_pkg::LDU_LB;
            1:       return lsu_pkg::LDU_LBU;
            2:       return lsu_pkg::LDU_LH;
            3:       return lsu_pkg::LDU_LHU;
            default: return lsu_pkg::LDU_LW;
        endcase
    endfunction

    function automatic lsu_pkg::stu_uop_t store_code(input int sel);
        case (sel % 3)
            0:       return lsu_pkg::STU_SB;
            1:       return lsu_pkg::STU_SH;
            default: return lsu_pkg::STU_SW;
        endcase
    endfunction

    // packet for the next issue, tag from the issue count
    task automatic drive_packet(input lsu_pkg::tag_t tag);
        instr_packet_i.valid       = 1'b1;
        instr_packet_i.tag         = tag;
        instr_packet_i.exception   = 1'b0;
        instr_packet_i.trap_vector = '0;
        sent_count[tag]            = sent_count[tag] + 1;
        issued_count               = issued_count + 1;
        first_issue                = 1'b1;
    endtask

    task automatic drive_load(input lsu_pkg::data_word_t addr, input lsu_pkg::ldu_uop_t uop);
        lsu_pkg::tag_t tag;
        tag               = lsu_pkg::tag_t'(issued_count);
        exp_is_load[tag]  = 1'b1;
        exp_trap[tag]     = 1'b0;
        exp_addr[tag]     = addr;
        exp_load_uop[tag] = uop;
        drive_packet(tag);
        ldu_valid_i   = 1'b1;
        ldu_address_i = addr;
        ldu_uop_i     = uop;
    endtask

    task automatic drive_store(input lsu_pkg::data_word_t addr, input lsu_pkg::data_word_t data,
                               input lsu_pkg::stu_uop_t uop);
        lsu_pkg::tag_t tag;
        tag                = lsu_pkg::tag_t'(issued_count);
        exp_is_load[tag]   = 1'b0;
        exp_trap[tag]      = store_misaligned(addr, uop);
        exp_addr[tag]      = addr;
        exp_wdata[tag]     = data;
        exp_store_uop[tag] = uop;
        drive_packet(tag);
        stu_valid_i   = 1'b1;
        stu_address_i = addr;
        stu_data_i    = data;
        stu_uop_i     = uop;
    endtask

    task automatic step();
        @(posedge clk_i);
        #0.5;
        ldu_valid_i = 1'b0;
        stu_valid_i = 1'b0;
    endtask

    task automatic wait_commits();
        while (commit_count != issued_count) begin
            @(posedge clk_i);
            #0.5;
        end
    endtask

    task automatic load_op(input lsu_pkg::data_word_t addr, input lsu_pkg::ldu_uop_t uop);
        drive_load(addr, uop);
        step();
        wait_commits();
    endtask

    task automatic store_op(input lsu_pkg::data_word_t addr, input lsu_pkg::data_word_t data,
                            input lsu_pkg::stu_uop_t uop);
        drive_store(addr, data, uop);
        step();
        wait_commits();
    endtask

    always_comb begin
        out_tag                 = instr_packet_o.tag;
        commit_known            = sent_count[out_tag] != seen_count[out_tag];
        want_packet.valid       = 1'b1;
        want_packet.tag         = out_tag;
        want_packet.exception   = exp_trap[out_tag];
        want_packet.trap_vector = exp_trap[out_tag] ? lsu_pkg::TRAP_ILLEGAL_ACCESS : '0;
        want_data = exp_is_load[out_tag] ?
                    expected_load(exp_addr[out_tag], exp_load_uop[out_tag]) : '0;
    end

    // commit bookkeeping and model update
    always @(posedge clk_i) begin : commit_track
        lsu_pkg::tag_t       t;
        logic [9:0]          a;
        lsu_pkg::data_word_t d;
        t = instr_packet_o.tag;
        a = exp_addr[t][9:0];
        d = exp_wdata[t];
        if (reset_i) begin
            for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;   // RAM starts at zero
        end else if (data_valid_o) begin
            seen_count[t]   <= seen_count[t] + 1;
            commit_cycle[t] <= cycle_count;
            commit_count    <= commit_count + 1;
            if (!exp_is_load[t] && !exp_trap[t]) begin
                ref_mem[a] = d[7:0];
                if (exp_store_uop[t] != lsu_pkg::STU_SB) ref_mem[a + 10'd1] = d[15:8];
                if (exp_store_uop[t] == lsu_pkg::STU_SW) begin
                    ref_mem[a + 10'd2] = d[23:16];
                    ref_mem[a + 10'd3] = d[31:24];
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout: no end of test after %0d cycles", cycle_count));
    end

    a_reset_quiet : assert property (@(posedge clk_i) disable iff (reset_i)
        !first_issue |-> (!data_valid_o && ldu_idle_o && stu_idle_o))
        else report_mismatch("commit or busy unit before the first issue");

    a_load_issue_idle : assert property (@(posedge clk_i) disable iff (reset_i)
        ldu_valid_i |-> ldu_idle_o)
        else abort_run("a load was issued while the load unit was busy");

    a_store_issue_idle : assert property (@(posedge clk_i) disable iff (reset_i)
        stu_valid_i |-> stu_idle_o)
        else abort_run("a store was issued while the store unit was busy");

    a_commit_known : assert property (@(posedge clk_i) disable iff (reset_i)
        data_valid_o |-> commit_known)
        else report_mismatch($sformatf("commit of tag %0d which is not outstanding", out_tag));

    a_commit_packet : assert property (@(posedge clk_i) disable iff (reset_i)
        data_valid_o |-> (instr_packet_o == want_packet))
        else report_mismatch($sformatf("tag %0d packet %h, expected %h",
                                       out_tag, instr_packet_o, want_packet));

    a_commit_data : assert property (@(posedge clk_i) disable iff (reset_i)
        data_valid_o |-> (data_o == want_data))
        else report_mismatch($sformatf("tag %0d data %h, expected %h",
                                       out_tag, data_o, want_data));

    initial begin
        logic [31:0]         rng_state;
        logic [31:0]         sel;
        lsu_pkg::data_word_t addr;
        lsu_pkg::tag_t       load_tag, store_tag;
        instr_packet_i = '0;
        ldu_valid_i    = 1'b0;
        ldu_address_i  = '0;
        ldu_uop_i      = lsu_pkg::LDU_LW;
        stu_valid_i    = 1'b0;
        stu_address_i  = '0;
        stu_data_i     = '0;
        stu_uop_i      = lsu_pkg::STU_SW;
        reset_i        = 1'b1;
        repeat (4) @(posedge clk_i);
        #0.5;
        reset_i = 1'b0;
        repeat (4) step();

        // store, load right behind it (forwarded), then again from RAM
        drive_store(32'h10, 32'hA5C3_0F96, lsu_pkg::STU_SW);
        step();
        drive_load(32'h10, lsu_pkg::LDU_LW);
        step();
        wait_commits();
        load_op(32'h10, lsu_pkg::LDU_LW);
        load_op(32'h12, lsu_pkg::LDU_LHU);

        // partial stores, load waits on the byte entry
        store_op(32'h20, 32'h1122_3344, lsu_pkg::STU_SW);
        drive_store(32'h21, 32'h0000_00F0, lsu_pkg::STU_SB);
        step();
        drive_load(32'h20, lsu_pkg::LDU_LW);
        step();
        wait_commits();
        store_op(32'h22, 32'h0000_8765, lsu_pkg::STU_SH);
        load_op(32'h21, lsu_pkg::LDU_LB);
        load_op(32'h21, lsu_pkg::LDU_LBU);
        load_op(32'h22, lsu_pkg::LDU_LH);
        load_op(32'h22, lsu_pkg::LDU_LHU);
        load_op(32'h23, lsu_pkg::LDU_LH);   // low bit ignored
        load_op(32'h22, lsu_pkg::LDU_LW);
        store_op(32'h23, 32'h0000_007F, lsu_pkg::STU_SB);
        load_op(32'h23, lsu_pkg::LDU_LB);
        load_op(32'h20, lsu_pkg::LDU_LW);

        // misaligned stores trap and leave memory alone
        store_op(32'h30, 32'hCAFE_BABE, lsu_pkg::STU_SW);
        store_op(32'h31, 32'h0000_1234, lsu_pkg::STU_SH);
        store_op(32'h32, 32'h5555_AAAA, lsu_pkg::STU_SW);
        store_op(32'h33, 32'h0F0F_0F0F, lsu_pkg::STU_SW);
        load_op(32'h30, lsu_pkg::LDU_LW);

        // load and store done in the same cycle, load must go first
        load_tag = lsu_pkg::tag_t'(issued_count);
        drive_load(32'h10, lsu_pkg::LDU_LW);
        step();
        store_tag = lsu_pkg::tag_t'(issued_count);
        drive_store(32'h44, 32'h0BAD_F00D, lsu_pkg::STU_SW);
        step();
        wait_commits();
        assert (commit_cycle[load_tag] < commit_cycle[store_tag])
            else report_mismatch($sformatf("store committed in cycle %0d before load in %0d",
                                           commit_cycle[store_tag], commit_cycle[load_tag]));

        rng_state = 32'd87;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng_state = xorshift32(rng_state);
            sel       = rng_state;
            rng_state = xorshift32(rng_state);
            addr      = WINDOW_BASE + {26'd0, rng_state[5:0]};
            rng_state = xorshift32(rng_state);
            if (sel[0]) load_op(addr, load_code(int'(sel[7:4])));
            else store_op(addr, rng_state, store_code(int'(sel[7:4])));
        end

        wait_commits();
        repeat (5) step();   // nothing further may commit
        if (issued_count != commit_count) begin
            abort_run($sformatf("%0d issued but %0d committed", issued_count, commit_count));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule : tb_lsu

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module lsu_top (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire lsu_pkg::instr_packet_t instr_packet_i,
    input  wire logic                  ldu_valid_i,
    input  wire lsu_pkg::data_word_t    ldu_address_i,
    input  wire lsu_pkg::ldu_uop_t      ldu_uop_i,
    input  wire logic                  stu_valid_i,
    input  wire lsu_pkg::data_word_t    stu_address_i,
    input  wire lsu_pkg::data_word_t    stu_data_i,
    input  wire lsu_pkg::stu_uop_t      stu_uop_i,
    output logic                       ldu_idle_o,
    output logic                       stu_idle_o,
    output lsu_pkg::instr_packet_t     instr_packet_o,
    output lsu_pkg::data_word_t        data_o,
    output logic                       data_valid_o
);

    logic                         buf_full, fwd_hit, fwd_conflict, push;
    logic                         mem_read, mem_data_valid, mem_write;
    lsu_pkg::data_word_t          fwd_data, mem_data, load_address;
    lsu_pkg::store_buffer_entry_t push_entry, mem_entry;

    load_store_unit i_load_store_unit (
        .clk_i (clk_i), .reset_i (reset_i), .instr_packet_i (instr_packet_i),
        .ldu_valid_i (ldu_valid_i), .ldu_address_i (ldu_address_i), .ldu_uop_i (ldu_uop_i),
        .stu_valid_i (stu_valid_i), .stu_address_i (stu_address_i),
        .stu_data_i (stu_data_i), .stu_uop_i (stu_uop_i),
        .buf_full_i (buf_full), .fwd_hit_i (fwd_hit), .fwd_conflict_i (fwd_conflict),
        .fwd_data_i (fwd_data), .mem_data_valid_i (mem_data_valid), .mem_data_i (mem_data),
        .ldu_idle_o (ldu_idle_o), .stu_idle_o (stu_idle_o), .mem_read_o (mem_read),
        .load_address_o (load_address), .push_o (push), .entry_o (push_entry),
        .instr_packet_o (instr_packet_o), .data_o (data_o), .data_valid_o (data_valid_o)
    );

    store_buffer i_store_buffer (
        .clk_i (clk_i), .reset_i (reset_i), .push_i (push), .entry_i (push_entry),
        .load_address_i (load_address), .full_o (buf_full), .fwd_hit_o (fwd_hit),
        .fwd_conflict_o (fwd_conflict), .fwd_data_o (fwd_data),
        .mem_write_o (mem_write), .mem_entry_o (mem_entry)
    );

    data_ram i_data_ram (
        .clk_i (clk_i), .read_i (mem_read), .read_address_i (load_address),
        .write_i (mem_write), .write_entry_i (mem_entry),
        .read_valid_o (mem_data_valid), .read_data_o (mem_data)
    );

endmodule : lsu_top

`default_nettype wire

// ==== hdl/data_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

module data_ram (
    input  wire logic                         clk_i,
    input  wire logic                         read_i,
    input  wire lsu_pkg::data_word_t           read_address_i,
    input  wire logic                         write_i,
    input  wire lsu_pkg::store_buffer_entry_t  write_entry_i,
    output logic                              read_valid_o,
    output lsu_pkg::data_word_t               read_data_o
);

    lsu_pkg::data_word_t mem [2**lsu_pkg::MEM_ADDR_BITS];
    lsu_pkg::mem_addr_t  raddr, waddr;

    // word index from the byte address
    assign raddr = read_address_i[lsu_pkg::MEM_ADDR_BITS+1:2];
    assign waddr = write_entry_i.address[lsu_pkg::MEM_ADDR_BITS+1:2];

    initial begin
        for (int i = 0; i < 2**lsu_pkg::MEM_ADDR_BITS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            for (int b = 0; b < 4; b++) begin
                if (write_entry_i.byte_en[b]) mem[waddr][8*b +: 8] <= write_entry_i.data[8*b +: 8];
            end
        end
    end

    // old data on a same-cycle write to the word
    always_ff @(posedge clk_i) begin
        read_valid_o <= read_i;
        if (read_i) read_data_o <= mem[raddr];
    end

endmodule : data_ram

`default_nettype wire

// ==== hdl/store_buffer.sv ====
`default_nettype none
`timescale 1ns/100ps

module store_buffer (
    input  wire logic                         clk_i,
    input  wire logic                         reset_i,
    input  wire logic                         push_i,
    input  wire lsu_pkg::store_buffer_entry_t  entry_i,
    input  wire lsu_pkg::data_word_t           load_address_i,
    output logic                              full_o,
    output logic                              fwd_hit_o,
    output logic                              fwd_conflict_o,
    output lsu_pkg::data_word_t               fwd_data_o,
    output logic                              mem_write_o,
    output lsu_pkg::store_buffer_entry_t      mem_entry_o
);

    typedef logic [lsu_pkg::STR_BUF_PTR_BITS-1:0] ptr_t;
    typedef logic [lsu_pkg::STR_BUF_PTR_BITS:0]   count_t;

    lsu_pkg::store_buffer_entry_t entries [lsu_pkg::STR_BUF_DEPTH];
    ptr_t                         head, tail;
    count_t                       count;
    logic                         pop;

    assign pop         = (count != '0);     // drain every cycle
    assign full_o      = (count == count_t'(lsu_pkg::STR_BUF_DEPTH));
    assign mem_write_o = pop;
    assign mem_entry_o = entries[head];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_i) tail <= tail + 1'b1;
            if (pop) head <= head + 1'b1;
            count <= count + count_t'(push_i) - count_t'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) entries[tail] <= entry_i;
    end

    // oldest to youngest, so the last match wins
    always_comb begin
        ptr_t                         idx;
        logic                         found;
        lsu_pkg::store_buffer_entry_t youngest;
        found    = 1'b0;
        youngest = '0;
        for (int i = 0; i < lsu_pkg::STR_BUF_DEPTH; i++) begin
            idx = head + ptr_t'(i);
            if (count_t'(i) < count && entries[idx].address == load_address_i) begin
                found    = 1'b1;
                youngest = entries[idx];
            end
        end
        fwd_hit_o      = found && (youngest.byte_en == 4'b1111);
        fwd_conflict_o = found && (youngest.byte_en != 4'b1111);
        fwd_data_o     = youngest.data;
    end

    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (reset_i) !(push_i && full_o)
    );

endmodule : store_buffer

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module load_store_unit (
    input  wire logic                         clk_i,
    input  wire logic                         reset_i,
    input  wire lsu_pkg::instr_packet_t        instr_packet_i,
    input  wire logic                         ldu_valid_i,
    input  wire lsu_pkg::data_word_t           ldu_address_i,
    input  wire lsu_pkg::ldu_uop_t             ldu_uop_i,
    input  wire logic                         stu_valid_i,
    input  wire lsu_pkg::data_word_t           stu_address_i,
    input  wire lsu_pkg::data_word_t           stu_data_i,
    input  wire lsu_pkg::stu_uop_t             stu_uop_i,
    input  wire logic                         buf_full_i,
    input  wire logic                         fwd_hit_i,
    input  wire logic                         fwd_conflict_i,
    input  wire lsu_pkg::data_word_t           fwd_data_i,
    input  wire logic                         mem_data_valid_i,
    input  wire lsu_pkg::data_word_t           mem_data_i,
    output logic                              ldu_idle_o,
    output logic                              stu_idle_o,
    output logic                              mem_read_o,
    output lsu_pkg::data_word_t               load_address_o,
    output logic                              push_o,
    output lsu_pkg::store_buffer_entry_t      entry_o,
    output lsu_pkg::instr_packet_t            instr_packet_o,
    output lsu_pkg::data_word_t               data_o,
    output logic                              data_valid_o
);

    logic                   ldu_done, stu_done, ldu_accept, stu_accept, stu_illegal;
    lsu_pkg::data_word_t    ldu_data;
    lsu_pkg::instr_packet_t ldu_packet, stu_packet;

    load_unit i_load_unit (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .valid_i          (ldu_valid_i),
        .address_i        (ldu_address_i),
        .uop_i            (ldu_uop_i),
        .accept_i         (ldu_accept),
        .fwd_hit_i        (fwd_hit_i),
        .fwd_conflict_i   (fwd_conflict_i),
        .fwd_data_i       (fwd_data_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .mem_read_o       (mem_read_o),
        .load_address_o   (load_address_o),
        .data_o           (ldu_data),
        .idle_o           (ldu_idle_o),
        .done_o           (ldu_done)
    );

    store_unit i_store_unit (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (stu_valid_i),
        .address_i  (stu_address_i),
        .data_i     (stu_data_i),
        .uop_i      (stu_uop_i),
        .accept_i   (stu_accept),
        .buf_full_i (buf_full_i),
        .push_o     (push_o),
        .entry_o    (entry_o),
        .illegal_o  (stu_illegal),
        .idle_o     (stu_idle_o),
        .done_o     (stu_done)
    );

    // packets follow their operation through the unit
    always_ff @(posedge clk_i) begin
        if (ldu_idle_o && ldu_valid_i) ldu_packet <= instr_packet_i;
        if (stu_idle_o && stu_valid_i) stu_packet <= instr_packet_i;
    end

    // commit port, load first
    assign ldu_accept   = ldu_done;
    assign stu_accept   = stu_done && !ldu_done;
    assign data_valid_o = ldu_done || stu_done;

    always_comb begin
        instr_packet_o = '0;
        data_o         = '0;
        if (ldu_accept) begin
            instr_packet_o = ldu_packet;
            data_o         = ldu_data;
        end else if (stu_accept) begin
            instr_packet_o = stu_packet;
            if (stu_illegal) begin
                instr_packet_o.exception   = 1'b1;
                instr_packet_o.trap_vector = lsu_pkg::TRAP_ILLEGAL_ACCESS;
            end
        end
    end

    // each unit frees itself right after its commit
    a_ldu_release : assert property (
        @(posedge clk_i) disable iff (reset_i) ldu_accept |=> ldu_idle_o
    );

    a_stu_release : assert property (
        @(posedge clk_i) disable iff (reset_i) stu_accept |=> stu_idle_o
    );

endmodule : load_store_unit

`default_nettype wire

// ==== hdl/store_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module store_unit (
    input  wire logic                         clk_i,
    input  wire logic                         reset_i,
    input  wire logic                         valid_i,
    input  wire lsu_pkg::data_word_t           address_i,
    input  wire lsu_pkg::data_word_t           data_i,
    input  wire lsu_pkg::stu_uop_t             uop_i,
    input  wire logic                         accept_i,
    input  wire logic                         buf_full_i,
    output logic                              push_o,
    output lsu_pkg::store_buffer_entry_t      entry_o,
    output logic                              illegal_o,
    output logic                              idle_o,
    output logic                              done_o
);

    typedef enum logic [1:0] {IDLE, CHECK, DONE} state_t;

    state_t              state;
    lsu_pkg::data_word_t addr_q;
    lsu_pkg::data_word_t data_q;
    lsu_pkg::stu_uop_t   uop_q;
    logic                misaligned;

    assign misaligned = (uop_q == lsu_pkg::STU_SH && addr_q[0]) ||
                        (uop_q == lsu_pkg::STU_SW && addr_q[1:0] != 2'b00);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state     <= IDLE;
            illegal_o <= 1'b0;
        end else begin
            case (state)
                IDLE: if (valid_i) begin
                    state     <= CHECK;
                    illegal_o <= 1'b0;
                end
                CHECK: if (misaligned) begin
                    state     <= DONE;
                    illegal_o <= 1'b1;  // refused, never pushed
                end else if (!buf_full_i) begin
                    state <= DONE;
                end
                DONE: if (accept_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && valid_i) begin
            addr_q <= address_i;
            data_q <= data_i;
            uop_q  <= uop_i;
        end
    end

    // byte lane placement
    always_comb begin
        entry_o.address = {addr_q[31:2], 2'b00};
        entry_o.data    = data_q << {addr_q[1:0], 3'b000};
        case (uop_q)
            lsu_pkg::STU_SB: entry_o.byte_en = 4'b0001 << addr_q[1:0];
            lsu_pkg::STU_SH: entry_o.byte_en = 4'b0011 << addr_q[1:0];
            default:         entry_o.byte_en = 4'b1111;
        endcase
    end

    assign push_o = (state == CHECK) && !misaligned && !buf_full_i;
    assign idle_o = (state == IDLE);
    assign done_o = (state == DONE);

    // a new store only while idle
    a_issue_when_idle : assert property (
        @(posedge clk_i) disable iff (reset_i) valid_i |-> idle_o
    );

endmodule : store_unit

`default_nettype wire

// ==== hdl/load_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module load_unit (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               valid_i,
    input  wire lsu_pkg::data_word_t address_i,
    input  wire lsu_pkg::ldu_uop_t   uop_i,
    input  wire logic               accept_i,
    input  wire logic               fwd_hit_i,
    input  wire logic               fwd_conflict_i,
    input  wire lsu_pkg::data_word_t fwd_data_i,
    input  wire logic               mem_data_valid_i,
    input  wire lsu_pkg::data_word_t mem_data_i,
    output logic                    mem_read_o,
    output lsu_pkg::data_word_t     load_address_o,
    output lsu_pkg::data_word_t     data_o,
    output logic                    idle_o,
    output logic                    done_o
);

    typedef enum logic [1:0] {IDLE, LOOKUP, WAIT_MEM, DONE} state_t;

    state_t              state, state_next;
    lsu_pkg::data_word_t addr_q;
    lsu_pkg::ldu_uop_t   uop_q;
    lsu_pkg::data_word_t word_q;    // raw word from buffer or RAM
    lsu_pkg::data_word_t shifted;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (valid_i) state_next = LOOKUP;
            LOOKUP:   if (fwd_hit_i) state_next = DONE;
                      else if (!fwd_conflict_i) state_next = WAIT_MEM;
            WAIT_MEM: if (mem_data_valid_i) state_next = DONE;
            DONE:     if (accept_i) state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && valid_i) begin
            uop_q <= uop_i;
            // drop the offset bits the size does not use
            case (uop_i)
                lsu_pkg::LDU_LW:                  addr_q <= {address_i[31:2], 2'b00};
                lsu_pkg::LDU_LH, lsu_pkg::LDU_LHU: addr_q <= {address_i[31:1], 1'b0};
                default:                          addr_q <= address_i;
            endcase
        end
        if (state == LOOKUP && fwd_hit_i) begin
            word_q <= fwd_data_i;
        end else if (state == WAIT_MEM && mem_data_valid_i) begin
            word_q <= mem_data_i;
        end
    end

    assign load_address_o = {addr_q[31:2], 2'b00};
    assign mem_read_o     = (state == LOOKUP) && !fwd_hit_i && !fwd_conflict_i;
    assign idle_o         = (state == IDLE);
    assign done_o         = (state == DONE);

    // lane select, then sign or zero extend
    always_comb begin
        shifted = word_q >> {addr_q[1:0], 3'b000};
        case (uop_q)
            lsu_pkg::LDU_LB:  data_o = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LDU_LBU: data_o = {24'b0, shifted[7:0]};
            lsu_pkg::LDU_LH:  data_o = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LDU_LHU: data_o = {16'b0, shifted[15:0]};
            default:          data_o = word_q;
        endcase
    end

    // the RAM answers the cycle after a read
    a_read_answered : assert property (
        @(posedge clk_i) disable iff (reset_i) mem_read_o |=> mem_data_valid_i
    );

endmodule : load_unit

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] data_word_t;   // data or byte address
    typedef logic [3:0]  byte_en_t;
    typedef logic [5:0]  tag_t;
    typedef logic [3:0]  trap_vector_t;

    // RAM geometry and store buffer depth
    localparam int MEM_ADDR_BITS    = 8;
    localparam int STR_BUF_DEPTH    = 4;
    localparam int STR_BUF_PTR_BITS = $clog2(STR_BUF_DEPTH);

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    typedef logic [2:0] ldu_uop_t;
    typedef logic [1:0] stu_uop_t;

    localparam ldu_uop_t LDU_LB  = 3'd0;
    localparam ldu_uop_t LDU_LH  = 3'd1;
    localparam ldu_uop_t LDU_LW  = 3'd2;
    localparam ldu_uop_t LDU_LBU = 3'd4;
    localparam ldu_uop_t LDU_LHU = 3'd5;

    localparam stu_uop_t STU_SB = 2'd0;
    localparam stu_uop_t STU_SH = 2'd1;
    localparam stu_uop_t STU_SW = 2'd2;

    // store address misaligned
    localparam trap_vector_t TRAP_ILLEGAL_ACCESS = 4'd6;

    typedef struct packed {
        logic         valid;
        tag_t         tag;
        logic         exception;
        trap_vector_t trap_vector;
    } instr_packet_t;

    // address is word aligned, data already sits in its byte lanes
    typedef struct packed {
        data_word_t address;
        data_word_t data;
        byte_en_t   byte_en;
    } store_buffer_entry_t;

endpackage : lsu_pkg

`default_nettype wire
